// ==== hw/tour_pkg.sv ====
// Board geometry and knight move encodings, imported by every block that handles moves or legs.
package tour_pkg;

  ////////////////////////////////////////
  // Board geometry.
  ////////////////////////////////////////
  localparam int BOARD_DIM = 5;   // Squares along one board edge.

  typedef logic [2:0] coord_t;    // One board coordinate.

  ////////////////////////////////////////
  // Stored tour moves.
  ////////////////////////////////////////
  // One-hot L-move. Vertical leg first, then horizontal leg.
  //   bit 0  2 north then 1 east.
  //   bit 1  2 north then 1 west.
  //   bit 2  1 north then 2 west.
  //   bit 3  1 south then 2 west.
  //   bit 4  2 south then 1 west.
  //   bit 5  2 south then 1 east.
  //   bit 6  1 south then 2 east.
  //   bit 7  1 north then 2 east.
  typedef logic [7:0] move_t;

  ////////////////////////////////////////
  // Leg of a move as sent to the mover.
  ////////////////////////////////////////
  typedef enum logic [7:0] {
    NORTH = 8'h00,                // Toward higher y.
    WEST  = 8'h3F,                // Toward lower x.
    SOUTH = 8'h7F,                // Toward lower y.
    EAST  = 8'hBF                 // Toward higher x.
  } heading_t;

  typedef struct packed {
    heading_t   heading;          // Direction of travel.
    logic [3:0] squares;          // Squares to cover.
  } leg_t;                        // 12 bits.

endpackage

// ==== hw/cmd_pkg.sv ====
// Command word layout, opcodes and response codes for the mover command port.
package cmd_pkg;
  import tour_pkg::*;

  ////////////////////////////////////////
  // Opcodes.
  ////////////////////////////////////////
  localparam logic [3:0] OP_MOVE     = 4'b0100;  // Move one leg.
  localparam logic [3:0] OP_MOVE_FAN = 4'b0101;  // Move one leg with fanfare.
  localparam logic [3:0] OP_SETPOS   = 4'b0010;  // Place the knight directly.

  ////////////////////////////////////////
  // Response codes.
  ////////////////////////////////////////
  localparam logic [7:0] RESP_DONE = 8'hA5;  // Tour finished.
  localparam logic [7:0] RESP_BUSY = 8'h5A;  // Command done, tour not over.

  ////////////////////////////////////////
  // Command word views.
  ////////////////////////////////////////
  // Move view. Opcode and one leg.
  typedef struct packed {
    logic [3:0] opcode;
    leg_t       leg;
  } mv_view_t;

  // Set-position view. Opcode and target square.
  typedef struct packed {
    logic [3:0] opcode;
    logic [5:0] unused;   // Ignored by the mover.
    coord_t     x;
    coord_t     y;
  } pos_view_t;

  // One 16-bit word, decoded per opcode.
  typedef union packed {
    mv_view_t  mv;        // OP_MOVE and OP_MOVE_FAN.
    pos_view_t pos;       // OP_SETPOS.
  } cmd_t;

endpackage

// ==== hw/move_store.sv ====
// Tour move memory, loaded by the host through a write strobe and read by the sequencer index.
`timescale 1ns/1ps

module move_store import tour_pkg::*; #(
  parameter  int NUM_MOVES = 24,
  localparam int IDX_W     = $clog2(NUM_MOVES)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             load_we,     // Host write strobe.
  input  logic [IDX_W-1:0] load_addr,   // Host write address.
  input  move_t            load_move,   // One-hot move to store.
  input  logic [IDX_W-1:0] mv_indx,     // Read address from sequencer.
  output move_t            move         // Move at mv_indx, one clock late.
);

  move_t mem [NUM_MOVES];   // Tour storage.

  ////////////////////////////////////////
  // Write port and registered read port.
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (load_we)
      mem[load_addr] <= load_move;   // Write lands on this edge.
    move <= mem[mv_indx];            // 1 cycle read latency.
  end

  ////////////////////////////////////////
  // Load checks.
  ////////////////////////////////////////
  // Host writes stay inside the tour and carry a legal one-hot move.
  a_load_legal : assert property (
    @(posedge clk) disable iff (!rst_n)
    load_we |-> (load_addr < IDX_W'(NUM_MOVES)) && $onehot(load_move)
  ) else $error("move_store: bad load addr %0d move %b", load_addr, load_move);

endmodule

// ==== hw/move_decoder.sv ====
// Splits a one-hot knight move into its vertical or horizontal leg for the sequencer.
`timescale 1ns/1ps

module move_decoder import tour_pkg::*; (
  input  move_t move,       // One-hot move from the store.
  input  logic  leg_horz,   // High selects the horizontal leg.
  output leg_t  leg         // Heading and square count.
);

  heading_t   vert_head;    // North or south.
  heading_t   horz_head;    // East or west.
  logic [3:0] vert_sq;      // 1 or 2.
  logic [3:0] horz_sq;      // The other of 1 or 2.

  always_comb begin
    unique case (1'b1)
      move[0]: begin
        vert_head = NORTH;
        vert_sq   = 4'd2;
        horz_head = EAST;
      end
      move[1]: begin
        vert_head = NORTH;
        vert_sq   = 4'd2;
        horz_head = WEST;
      end
      move[2]: begin
        vert_head = NORTH;
        vert_sq   = 4'd1;
        horz_head = WEST;
      end
      move[3]: begin
        vert_head = SOUTH;
        vert_sq   = 4'd1;
        horz_head = WEST;
      end
      move[4]: begin
        vert_head = SOUTH;
        vert_sq   = 4'd2;
        horz_head = WEST;
      end
      move[5]: begin
        vert_head = SOUTH;
        vert_sq   = 4'd2;
        horz_head = EAST;
      end
      move[6]: begin
        vert_head = SOUTH;
        vert_sq   = 4'd1;
        horz_head = EAST;
      end
      move[7]: begin
        vert_head = NORTH;
        vert_sq   = 4'd1;
        horz_head = EAST;
      end
      default: begin                   // Empty move never reaches a leg.
        vert_head = heading_t'(8'hxx);
        vert_sq   = 4'hx;
        horz_head = heading_t'(8'hxx);
      end
    endcase
  end

  assign horz_sq = 4'd3 - vert_sq;     // An L covers 3 squares in all.

  // Pick the requested leg.
  always_comb begin
    if (leg_horz) begin
      leg.heading = horz_head;
      leg.squares = horz_sq;
    end else begin
      leg.heading = vert_head;
      leg.squares = vert_sq;
    end
  end

endmodule

// ==== hw/tour_sequencer.sv ====
// Tour FSM that walks the stored moves, forms leg commands and shares the mover with the host port.
`timescale 1ns/1ps

module tour_sequencer import tour_pkg::*, cmd_pkg::*; #(
  parameter  int NUM_MOVES = 24,
  localparam int IDX_W     = $clog2(NUM_MOVES)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start_tour,    // Replay request.
  input  leg_t             leg,           // Decoded leg of current move.
  input  cmd_t             ext_cmd,       // Host command.
  input  logic             ext_cmd_rdy,   // Host command valid.
  input  logic             clr_cmd_rdy,   // Mover took the command.
  input  logic             send_resp,     // Mover finished the command.
  output logic [IDX_W-1:0] mv_indx,       // Current move index.
  output logic             leg_horz,      // Horizontal leg in progress.
  output cmd_t             cmd,           // Muxed command to mover.
  output logic             cmd_rdy,       // Muxed command valid.
  output logic             ext_ack,       // Host command taken.
  output logic [7:0]       resp,          // Response code.
  output logic             fanfare,       // End of an L, or fanfare move done.
  output logic             tour_busy      // Tour owns the mover.
);

  typedef enum logic [2:0] {IDLE, FETCH, VERT, HOLDV, HORZ, HOLDH} state_t;

  state_t state;
  state_t nxt_state;
  logic   clr_index;     // Restart at move 0.
  logic   inc_index;     // Advance to next move.
  logic   last_move;     // Index points at final move.
  logic   tour_rdy;      // Tour side command valid.
  logic   ext_fan;       // Host command in flight was OP_MOVE_FAN.
  cmd_t   tour_cmd;      // Tour side command word.

  ////////////////////////////////////////
  // Move index.
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      mv_indx <= '0;
    else if (clr_index)
      mv_indx <= '0;
    else if (inc_index)
      mv_indx <= mv_indx + 1'b1;
  end

  assign last_move = (mv_indx == IDX_W'(NUM_MOVES - 1));

  ////////////////////////////////////////
  // State machine.
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    clr_index = 1'b0;
    inc_index = 1'b0;
    case (state)
      IDLE: begin
        if (start_tour) begin
          clr_index = 1'b1;
          nxt_state = FETCH;              // Let the store read move 0.
        end
      end
      FETCH: nxt_state = VERT;            // Move valid from next cycle.
      VERT:  if (clr_cmd_rdy) nxt_state = HOLDV;
      HOLDV: if (send_resp) nxt_state = HORZ;
      HORZ:  if (clr_cmd_rdy) nxt_state = HOLDH;
      HOLDH: begin
        if (send_resp) begin
          if (last_move) begin
            nxt_state = IDLE;             // Tour complete.
          end else begin
            inc_index = 1'b1;
            nxt_state = FETCH;
          end
        end
      end
      default: nxt_state = IDLE;
    endcase
  end

  assign tour_busy = (state != IDLE);
  assign leg_horz  = (state == HORZ) || (state == HOLDH);
  assign tour_rdy  = (state == VERT) || (state == HORZ);   // Drops once taken.

  ////////////////////////////////////////
  // Command forming and mux.
  ////////////////////////////////////////
  always_comb begin
    tour_cmd            = '0;
    tour_cmd.mv.opcode  = leg_horz ? OP_MOVE_FAN : OP_MOVE;   // Fanfare closes the L.
    tour_cmd.mv.leg     = leg;
  end

  assign cmd     = tour_busy ? tour_cmd : ext_cmd;
  assign cmd_rdy = tour_busy ? tour_rdy : ext_cmd_rdy;
  assign ext_ack = clr_cmd_rdy & ~tour_busy;      // Host sees only its own ack.

  // Remember whether the host asked for fanfare.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      ext_fan <= 1'b0;
    else if (ext_ack)
      ext_fan <= (ext_cmd.mv.opcode == OP_MOVE_FAN);
  end

  ////////////////////////////////////////
  // Response side.
  ////////////////////////////////////////
  assign fanfare = send_resp & ((state == HOLDH) | (~tour_busy & ext_fan));
  assign resp    = ((state == HOLDH) && last_move) ? RESP_DONE : RESP_BUSY;

  // Host must not restart a running tour.
  a_no_restart : assert property (
    @(posedge clk) disable iff (!rst_n)
    start_tour |-> !tour_busy
  ) else $error("tour_sequencer: start_tour while busy");

  // Tour command holds until the mover takes it.
  a_cmd_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    tour_busy && cmd_rdy && !clr_cmd_rdy |=> $stable(cmd)
  ) else $error("tour_sequencer: cmd changed before clr_cmd_rdy");

endmodule

// ==== hw/knight_mover.sv ====
// Mover that executes leg and set-position commands one square at a time and answers each one.
`timescale 1ns/1ps

module knight_mover import tour_pkg::*, cmd_pkg::*; #(
  parameter int SQUARE_CYCLES = 4
) (
  input  logic   clk,
  input  logic   rst_n,
  input  cmd_t   cmd,           // Command word.
  input  logic   cmd_rdy,       // Command valid.
  output logic   clr_cmd_rdy,   // Pulse when command latched.
  output logic   send_resp,     // Pulse when command finished.
  output coord_t pos_x,         // Knight column.
  output coord_t pos_y          // Knight row.
);

  localparam int CYC_W = (SQUARE_CYCLES > 1) ? $clog2(SQUARE_CYCLES) : 1;

  typedef enum logic [1:0] {M_IDLE, M_MOVE, M_FIN} mstate_t;

  mstate_t          state;
  cmd_t             cmd_q;       // Latched command.
  logic [3:0]       sq_left;     // Squares still to cover.
  logic [CYC_W-1:0] cyc_cnt;     // Clocks into current square.
  logic             is_move;     // Incoming opcode moves the knight.
  logic             sq_end;      // Last clock of a square.
  coord_t           step_x;      // Position after one square.
  coord_t           step_y;

  assign is_move = (cmd.mv.opcode == OP_MOVE) || (cmd.mv.opcode == OP_MOVE_FAN);
  assign sq_end  = (cyc_cnt == CYC_W'(SQUARE_CYCLES - 1));

  always_ff @(posedge clk) begin
    if ((state == M_IDLE) && cmd_rdy)
      cmd_q <= cmd;
  end

  // One square along the latched heading. North is +y, east is +x.
  always_comb begin
    step_x = pos_x;
    step_y = pos_y;
    case (cmd_q.mv.leg.heading)
      NORTH:   step_y = pos_y + 3'd1;
      SOUTH:   step_y = pos_y - 3'd1;
      EAST:    step_x = pos_x + 3'd1;
      WEST:    step_x = pos_x - 3'd1;
      default: ;                          // Bad heading stands still.
    endcase
  end

  ////////////////////////////////////////
  // Execution.
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= M_IDLE;
      clr_cmd_rdy <= 1'b0;
      send_resp   <= 1'b0;
      sq_left     <= '0;
      cyc_cnt     <= '0;
      pos_x       <= '0;
      pos_y       <= '0;
    end else begin
      clr_cmd_rdy <= 1'b0;               // Both strobes are single pulses.
      send_resp   <= 1'b0;
      case (state)
        M_IDLE: begin
          if (cmd_rdy) begin
            clr_cmd_rdy <= 1'b1;
            sq_left     <= cmd.mv.leg.squares;
            cyc_cnt     <= '0;
            state       <= is_move ? M_MOVE : M_FIN;
          end
        end
        M_MOVE: begin
          if (sq_left == 4'd0) begin       // Empty leg answers at once.
            send_resp <= 1'b1;
            state     <= M_IDLE;
          end else if (sq_end) begin
            cyc_cnt <= '0;
            pos_x   <= step_x;
            pos_y   <= step_y;
            sq_left <= sq_left - 4'd1;
            if (sq_left == 4'd1) begin
              send_resp <= 1'b1;
              state     <= M_IDLE;
            end
          end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end
        M_FIN: begin                       // Set-position or unknown opcode.
          if (cmd_q.pos.opcode == OP_SETPOS) begin
            pos_x <= cmd_q.pos.x;
            pos_y <= cmd_q.pos.y;
          end
          send_resp <= 1'b1;
          state     <= M_IDLE;
        end
        default: state <= M_IDLE;
      endcase
    end
  end

  // Every command stream keeps the knight on the board.
  a_on_board : assert property (
    @(posedge clk) disable iff (!rst_n)
    (pos_x < coord_t'(BOARD_DIM)) && (pos_y < coord_t'(BOARD_DIM))
  ) else $error("knight_mover: off board at (%0d,%0d)", pos_x, pos_y);

endmodule

// ==== hw/knight_top.sv ====
// Top level of the tour replay, joining store, decoder, sequencer and mover for the host.
`timescale 1ns/1ps

module knight_top import tour_pkg::*, cmd_pkg::*; #(
  parameter  int NUM_MOVES     = 24,
  parameter  int SQUARE_CYCLES = 4,
  localparam int IDX_W         = $clog2(NUM_MOVES)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             load_we,       // Tour load strobe.
  input  logic [IDX_W-1:0] load_addr,
  input  move_t            load_move,
  input  logic             start_tour,
  input  cmd_t             ext_cmd,       // Host command port.
  input  logic             ext_cmd_rdy,
  output logic             ext_ack,
  output logic [7:0]       resp,
  output logic             resp_vld,
  output logic             fanfare,
  output logic             tour_busy,
  output coord_t           pos_x,
  output coord_t           pos_y
);

  move_t            move;          // Store to decoder.
  logic [IDX_W-1:0] mv_indx;       // Sequencer to store.
  logic             leg_horz;      // Sequencer to decoder.
  leg_t             leg;           // Decoder to sequencer.
  cmd_t             cmd;           // Sequencer to mover.
  logic             cmd_rdy;
  logic             clr_cmd_rdy;   // Mover back to sequencer.
  logic             send_resp;

  move_store #(.NUM_MOVES(NUM_MOVES)) u_store (
    .clk, .rst_n, .load_we, .load_addr, .load_move, .mv_indx, .move
  );

  move_decoder u_decoder (
    .move, .leg_horz, .leg
  );

  tour_sequencer #(.NUM_MOVES(NUM_MOVES)) u_seq (
    .clk, .rst_n, .start_tour, .leg, .ext_cmd, .ext_cmd_rdy, .clr_cmd_rdy,
    .send_resp, .mv_indx, .leg_horz, .cmd, .cmd_rdy, .ext_ack, .resp,
    .fanfare, .tour_busy
  );

  knight_mover #(.SQUARE_CYCLES(SQUARE_CYCLES)) u_mover (
    .clk, .rst_n, .cmd, .cmd_rdy, .clr_cmd_rdy, .send_resp, .pos_x, .pos_y
  );

  assign resp_vld = send_resp;   // Response strobe to host.

endmodule

// ==== bench/knight_tb.sv ====
// Table-driven testbench for the knight tour replay; a board model predicts every response pulse.
`timescale 1ns/1ps

module knight_tb import tour_pkg::*, cmd_pkg::*; ();

  localparam int NUM_MOVES = 24;
  localparam int TMO       = 5000;            // Cycle limit for any single wait.
  localparam logic [1:0] K_LOAD   = 2'd0;
  localparam logic [1:0] K_SETPOS = 2'd1;
  localparam logic [1:0] K_MOVE   = 2'd2;
  localparam logic [1:0] K_START  = 2'd3;

  typedef struct packed {
    logic [1:0]  kind;                        // Step kind.
    logic [15:0] data;                        // Command word, or host word held during a tour.
    coord_t      x;                           // Expected final square.
    coord_t      y;
  } step_t;

  typedef struct packed {
    coord_t     x;
    coord_t     y;
    logic [7:0] resp;
    logic       fan;
  } exp_t;                                    // Expected state at one resp_vld.

  logic       clk;
  logic       rst_n;
  logic       load_we;
  logic [4:0] load_addr;
  move_t      load_move;
  logic       start_tour;
  cmd_t       ext_cmd;
  logic       ext_cmd_rdy;
  logic       ext_ack;
  logic [7:0] resp;
  logic       resp_vld;
  logic       fanfare;
  logic       tour_busy;
  coord_t     pos_x;
  coord_t     pos_y;

  int   errors  = 0;
  int   ack_cnt = 0;                          // ext_ack pulses seen.
  int   vld_cnt = 0;                          // resp_vld pulses seen.
  int   mx;                                   // Model position.
  int   my;
  exp_t exp_q [$];

  // Open 5x5 tour from (0,0), ending at (2,2).
  move_t tour [NUM_MOVES] = '{
    8'h80, 8'h40, 8'h02, 8'h01, 8'h08, 8'h04, 8'h20, 8'h20,
    8'h80, 8'h02, 8'h04, 8'h10, 8'h20, 8'h80, 8'h01, 8'h04,
    8'h08, 8'h20, 8'h40, 8'h01, 8'h02, 8'h08, 8'h10, 8'h80
  };
  int dy_tab [8] = '{2, 2, 1, -1, -2, -2, -1, 1};   // North part of move bit k.
  int dx_tab [8] = '{1, -1, -2, -2, -1, 1, 2, 2};   // East part of move bit k.

  step_t steps [10] = '{
    '{K_LOAD,   16'h0000, 3'd0, 3'd0},        // Store only, knight stays home.
    '{K_SETPOS, 16'h2011, 3'd2, 3'd1},
    '{K_MOVE,   16'h4002, 3'd2, 3'd3},        // North 2.
    '{K_MOVE,   16'h5BF2, 3'd4, 3'd3},        // East 2, fanfare.
    '{K_MOVE,   16'h47F3, 3'd4, 3'd0},        // South 3.
    '{K_MOVE,   16'h53F4, 3'd0, 3'd0},        // West 4, fanfare.
    '{K_SETPOS, 16'h2000, 3'd0, 3'd0},
    '{K_START,  16'h2024, 3'd2, 3'd2},        // Host setpos to (4,4) held mid tour.
    '{K_SETPOS, 16'h2000, 3'd0, 3'd0},
    '{K_START,  16'h0000, 3'd2, 3'd2}         // Plain replay.
  };

  knight_top #(.NUM_MOVES(NUM_MOVES), .SQUARE_CYCLES(4)) UUT (
    .clk, .rst_n, .load_we, .load_addr, .load_move, .start_tour, .ext_cmd, .ext_cmd_rdy,
    .ext_ack, .resp, .resp_vld, .fanfare, .tour_busy, .pos_x, .pos_y
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                   // 20 ns period.
  end

  ////////////////////////////////////////
  // Checks and waits.
  ////////////////////////////////////////
  function automatic void check_val(string name, int exp_v, int got_v);
    assert (got_v == exp_v) else begin
      errors++;
      $display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, exp_v, got_v);
    end
  endfunction

  task automatic abort_run(string what);
    errors++;
    $display("ERROR: timed out at %0t ns waiting for %s", $time, what);
    $display("Errors: %0d", errors);
    $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic wait_drain(string what);
    int n;
    n = 0;
    while (exp_q.size() != 0) begin          // Monitor pops one entry per pulse.
      @(negedge clk);
      n++;
      if (n > TMO)
        abort_run(what);
    end
  endtask

  // Response monitor. Outputs settle after the rising edge.
  always @(negedge clk) begin : monitor
    exp_t e;
    if (rst_n) begin
      if (ext_ack)
        ack_cnt++;
      if (resp_vld) begin
        vld_cnt++;
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("ERROR: resp_vld at %0t ns with no response expected", $time);
        end
        if (exp_q.size() != 0) begin
          e = exp_q.pop_front();
          check_val("pos_x", e.x, pos_x);
          check_val("pos_y", e.y, pos_y);
          check_val("resp", e.resp, resp);
          check_val("fanfare", e.fan, fanfare);
        end
      end
    end
  end

  ////////////////////////////////////////
  // Step kinds.
  ////////////////////////////////////////
  task automatic load_tour();
    int i;
    for (i = 0; i < NUM_MOVES; i++) begin
      @(negedge clk);
      load_we   = 1'b1;
      load_addr = 5'(i);
      load_move = tour[i];
    end
    @(negedge clk);
    load_we = 1'b0;
  endtask

  task automatic send_ext(input logic [15:0] word);
    int   n;
    int   acks;
    exp_t e;
    if (word[15:12] == OP_SETPOS) begin
      mx = word[5:3];
      my = word[2:0];
    end else begin
      case (word[11:4])                       // Heading rule, north is +y, east is +x.
        NORTH:   my = my + word[3:0];
        SOUTH:   my = my - word[3:0];
        EAST:    mx = mx + word[3:0];
        WEST:    mx = mx - word[3:0];
        default: ;
      endcase
    end
    e = '{coord_t'(mx), coord_t'(my), RESP_BUSY, word[15:12] == OP_MOVE_FAN};
    exp_q.push_back(e);
    acks = ack_cnt;
    @(negedge clk);
    ext_cmd     = word;
    ext_cmd_rdy = 1'b1;
    n = 0;
    while (!ext_ack) begin
      @(negedge clk);
      n++;
      if (n > TMO)
        abort_run("ext_ack");
    end
    ext_cmd_rdy = 1'b0;                       // Dropped inside the ack cycle.
    wait_drain("ext command response");
    check_val("ext_ack pulses", 1, ack_cnt - acks);
  endtask

  task automatic run_tour(input logic [15:0] intrude);
    int i;
    int k;
    int n;
    int acks;
    int vlds;
    for (i = 0; i < NUM_MOVES; i++) begin
      for (k = 0; k < 8; k++)
        if (tour[i][k])
          break;
      my = my + dy_tab[k];                    // Vertical leg first.
      exp_q.push_back('{coord_t'(mx), coord_t'(my), RESP_BUSY, 1'b0});
      mx = mx + dx_tab[k];
      exp_q.push_back('{coord_t'(mx), coord_t'(my),
                        (i == NUM_MOVES - 1) ? RESP_DONE : RESP_BUSY, 1'b1});
    end
    acks = ack_cnt;
    vlds = vld_cnt;
    @(negedge clk);
    start_tour = 1'b1;
    @(negedge clk);
    start_tour = 1'b0;
    check_val("tour_busy", 1, tour_busy);     // Tour owns the mover from here.
    if (intrude != 16'h0000) begin
      ext_cmd     = intrude;
      ext_cmd_rdy = 1'b1;                     // Host knocks while the tour runs.
    end
    n = 0;
    while (ext_cmd_rdy && (vld_cnt - vlds < 10)) begin
      @(negedge clk);
      n++;
      if (n > TMO)
        abort_run("tour progress");
    end
    ext_cmd_rdy = 1'b0;                       // Withdrawn long before the tour ends.
    wait_drain("tour responses");
    n = 0;
    while (tour_busy) begin
      @(negedge clk);
      n++;
      if (n > TMO)
        abort_run("tour_busy to fall");
    end
    check_val("ext_ack during tour", 0, ack_cnt - acks);
    check_val("resp_vld pulses", 2 * NUM_MOVES, vld_cnt - vlds);
  endtask

  ////////////////////////////////////////
  // Main sequence.
  ////////////////////////////////////////
  initial begin : stimulus
    int r;
    int gap;
    void'($urandom(32'h2730));
    rst_n       = 1'b0;
    load_we     = 1'b0;
    load_addr   = '0;
    load_move   = '0;
    start_tour  = 1'b0;
    ext_cmd     = '0;
    ext_cmd_rdy = 1'b0;
    mx          = 0;
    my          = 0;
    repeat (4) @(posedge clk);                // Reset spans 4 rising edges.
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_val("pos_x", 0, pos_x);             // Reset state.
    check_val("pos_y", 0, pos_y);
    check_val("tour_busy", 0, tour_busy);
    check_val("resp_vld", 0, resp_vld);
    check_val("fanfare", 0, fanfare);
    for (r = 0; r < 10; r++) begin
      gap = $urandom_range(1, 6);
      repeat (gap) @(negedge clk);
      case (steps[r].kind)
        K_LOAD:  load_tour();
        K_START: run_tour(steps[r].data);
        default: send_ext(steps[r].data);     // Setpos and move share the host port.
      endcase
      check_val("pos_x", steps[r].x, pos_x);
      check_val("pos_y", steps[r].y, pos_y);
    end
    repeat (4) @(negedge clk);
    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== project.f ====
hw/tour_pkg.sv
hw/cmd_pkg.sv
hw/move_store.sv
hw/move_decoder.sv
hw/tour_sequencer.sv
hw/knight_mover.sv
hw/knight_top.sv
bench/knight_tb.sv
